/* Bender.yml */
package:
  name: fetch_frontend

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/fetch_pkg.sv
      - src/isa_pkg.sv
      - src/fetch_if.sv
      - src/fetch_pc.sv
      - src/if_stage.sv
      - src/id_stage.sv
      - src/fetch_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_fetch_top.sv

/* files.f */
+incdir+src
src/fetch_pkg.sv
src/isa_pkg.sv
src/fetch_if.sv
src/fetch_pc.sv
src/if_stage.sv
src/id_stage.sv
src/fetch_top.sv
tests/tb_clk_gen.sv
tests/tb_fetch_top.sv

/* src/fetch_cfg.svh */
// fetch configuration, the pc and SRAM address widths must stay equal and the SRAM is 64 bits wide
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first instruction after reset
`define FETCH_PC_RESETVAL     32'h8000_0000

// datapath widths
`define FETCH_PC_WD           32
`define FETCH_INST_WD         32
`define FETCH_SRAM_ADDR_WD    32
`define FETCH_SRAM_DATA_WD    64

// alignment
`define FETCH_INST_BYTES      4   // sequential pc step
`define FETCH_DWORD_OFS_BITS  3   // byte offset bits inside one SRAM doubleword

`endif

/* src/fetch_if.sv */
// IF to ID handshake, a transfer needs valid and allowin high on the same rising edge
`timescale 1ns/10ps

interface fetch_if;
  import fetch_pkg::*;

  logic  valid;    // IF holds an instruction for ID
  inst_t inst;
  pc_t   pc;
  logic  allowin;  // ID can take it this cycle

  // fetch side drives the payload
  modport if_side (
    output valid,
    output inst,
    output pc,
    input  allowin
  );

  // decode side answers with allowin
  modport id_side (
    input  valid,
    input  inst,
    input  pc,
    output allowin
  );

endinterface

/* src/fetch_pc.sv */
// pc register and SRAM read request, assumes single-cycle SRAM reads and word aligned targets
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_pc (
  input  logic                  i_clk,
  input  logic                  i_arst_n,
  input  logic                  i_load,           // pre-IF ready and IF allowin
  input  logic                  i_br_sel,         // JAL resolved in ID
  input  fetch_pkg::pc_t        i_br_target,
  output fetch_pkg::pc_t        o_pc,
  output logic                  o_inst_sram_ren,
  output fetch_pkg::sram_addr_t o_inst_sram_addr
);
  import fetch_pkg::*;

  localparam int unsigned INST_OFS_BITS = $clog2(`FETCH_INST_BYTES);

  pc_t pc_q;
  pc_t pc_nxt;

  // branch wins over the sequential step
  assign pc_nxt = i_br_sel ? i_br_target : pc_q + pc_t'(`FETCH_INST_BYTES);

  // one step below the reset pc so the first load lands on it
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= pc_t'(`FETCH_PC_RESETVAL - `FETCH_INST_BYTES);
    end else if (i_load) begin
      pc_q <= pc_nxt;
    end
  end

  assign o_pc            = pc_q;
  assign o_inst_sram_ren = i_load;  // read exactly when the pc moves

  // new pc, dropped to its doubleword
  assign o_inst_sram_addr = sram_addr_t'({pc_nxt[`FETCH_PC_WD-1:`FETCH_DWORD_OFS_BITS],
                                          {`FETCH_DWORD_OFS_BITS{1'b0}}});

  // targets come from ID, a misaligned one would break the half select
  a_pc_aligned: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    pc_q[INST_OFS_BITS-1:0] == '0
  ) else $error("fetch_pc: pc %h not word aligned", pc_q);

endmodule

/* src/fetch_pkg.sv */
// fetch datapath types, widths come from the cfg header and must not be overridden per instance
`include "fetch_cfg.svh"

package fetch_pkg;

  // instruction address
  typedef logic [`FETCH_PC_WD-1:0] pc_t;

  // one RV32 instruction word
  typedef logic [`FETCH_INST_WD-1:0] inst_t;

  // byte address towards the instruction SRAM, always doubleword aligned
  typedef logic [`FETCH_SRAM_ADDR_WD-1:0] sram_addr_t;

  // one doubleword as returned by the SRAM
  typedef logic [`FETCH_SRAM_DATA_WD-1:0] sram_data_t;

endpackage

/* src/fetch_top.sv */
// fetch front-end top, expects a synchronous 64-bit instruction SRAM with no wait states
`timescale 1ns/10ps

module fetch_top (
  input  logic                  i_clk,
  input  logic                  i_arst_n,
  // downstream back-pressure
  input  logic                  i_es_allowin,
  // instruction SRAM
  output logic                  o_inst_sram_ren,
  output fetch_pkg::sram_addr_t o_inst_sram_addr,
  input  fetch_pkg::sram_data_t i_inst_sram_rdata,
  // decoded instruction out
  output logic                  o_id_valid,
  output fetch_pkg::inst_t      o_id_inst,
  output fetch_pkg::pc_t        o_id_pc
);
  import fetch_pkg::*;

  logic br_sel;     // one-cycle JAL redirect
  pc_t  br_target;

  fetch_if u_fs_ds ();

  if_stage u_if (
    .i_clk             (i_clk),
    .i_arst_n          (i_arst_n),
    .i_br_sel          (br_sel),
    .i_br_target       (br_target),
    .o_fs              (u_fs_ds.if_side),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  id_stage u_id (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_ds         (u_fs_ds.id_side),
    .i_es_allowin (i_es_allowin),
    .o_br_sel     (br_sel),
    .o_br_target  (br_target),
    .o_id_valid   (o_id_valid),
    .o_id_inst    (o_id_inst),
    .o_id_pc      (o_id_pc)
  );

endmodule

/* src/id_stage.sv */
// ID register stage, decodes only JAL and leaves every other opcode to later stages
`timescale 1ns/10ps

module id_stage (
  input  logic           i_clk,
  input  logic           i_arst_n,
  // from IF
  fetch_if.id_side       i_ds,
  input  logic           i_es_allowin,  // downstream back-pressure
  // branch back to fetch
  output logic           o_br_sel,
  output fetch_pkg::pc_t o_br_target,
  // to the next stage
  output logic           o_id_valid,
  output fetch_pkg::inst_t o_id_inst,
  output fetch_pkg::pc_t o_id_pc
);
  import fetch_pkg::*;
  import isa_pkg::*;

  logic    ds_valid;
  logic    ds_allowin;
  inst_t   ds_inst;
  pc_t     ds_pc;
  opcode_e ds_opcode;
  jimm_t   ds_jimm;
  logic    ds_is_jal;

  assign ds_allowin   = !ds_valid || i_es_allowin;
  assign i_ds.allowin = ds_allowin;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= i_ds.valid;
    end
  end

  // payload only moves on a real transfer
  always_ff @(posedge i_clk) begin
    if (i_ds.valid && ds_allowin) begin
      ds_inst <= i_ds.inst;
      ds_pc   <= i_ds.pc;
    end
  end

  // decode
  assign ds_opcode = opcode_e'(ds_inst[6:0]);
  assign ds_is_jal = ds_opcode == OP_JAL;
  assign ds_jimm   = j_imm(ds_inst);

  // redirect only as the JAL leaves, so it fires once
  assign o_br_sel    = ds_valid && ds_is_jal && i_es_allowin;
  assign o_br_target = ds_pc + ds_jimm;

  assign o_id_valid = ds_valid;
  assign o_id_inst  = ds_inst;
  assign o_id_pc    = ds_pc;

  // IF drops its word in the redirect cycle, so ID must be empty right after
  a_br_flush: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    o_br_sel |-> (o_id_valid && i_es_allowin) ##1 !o_id_valid
  ) else $error("id_stage: wrong-path instruction entered ID after JAL");

endmodule

/* src/if_stage.sv */
// IF stage with pre-IF request, needs SRAM data one cycle after ren and held while ren is low
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module if_stage (
  input  logic                  i_clk,
  input  logic                  i_arst_n,
  // branch back from ID
  input  logic                  i_br_sel,
  input  fetch_pkg::pc_t        i_br_target,
  // to ID
  fetch_if.if_side              o_fs,
  // instruction SRAM
  output logic                  o_inst_sram_ren,
  output fetch_pkg::sram_addr_t o_inst_sram_addr,
  input  fetch_pkg::sram_data_t i_inst_sram_rdata
);
  import fetch_pkg::*;

  localparam int unsigned HALF_SEL = `FETCH_DWORD_OFS_BITS - 1;  // pc bit 2

  logic  to_fs_valid;  // pre-IF has an address to issue
  logic  fs_valid;
  logic  fs_allowin;
  logic  pc_load;
  pc_t   fs_pc;
  inst_t fs_inst;

  // pre-IF, comes up the cycle after reset and stays up
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      to_fs_valid <= 1'b0;
    end else begin
      to_fs_valid <= 1'b1;
    end
  end

  // empty, or ID takes what we hold
  assign fs_allowin = !fs_valid || o_fs.allowin;
  assign pc_load    = to_fs_valid && fs_allowin;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= to_fs_valid;  // data arrives with the read issued this cycle
    end
  end

  fetch_pc u_pc (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_load           (pc_load),
    .i_br_sel         (i_br_sel),
    .i_br_target      (i_br_target),
    .o_pc             (fs_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  // doubleword SRAM, pick the word the pc points at
  assign fs_inst = fs_pc[HALF_SEL] ?
                   i_inst_sram_rdata[`FETCH_SRAM_DATA_WD-1 -: `FETCH_INST_WD] :
                   i_inst_sram_rdata[`FETCH_INST_WD-1:0];

  // the word behind a taken JAL is wrong-path
  assign o_fs.valid = fs_valid && !i_br_sel;
  assign o_fs.inst  = fs_inst;
  assign o_fs.pc    = fs_pc;

  // payload is built from the pc and the held SRAM data, both must freeze on a stall
  a_fs_hold: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (o_fs.valid && !o_fs.allowin) |=> ($stable(o_fs.inst) && $stable(o_fs.pc))
  ) else $error("if_stage: payload changed while stalled");

endmodule

/* src/isa_pkg.sv */
// RV32I opcode and immediate helpers, only the base 32-bit encodings are covered
package isa_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b000_0011,
    OP_FENCE  = 7'b000_1111,
    OP_IMM    = 7'b001_0011,
    OP_AUIPC  = 7'b001_0111,
    OP_STORE  = 7'b010_0011,
    OP_REG    = 7'b011_0011,
    OP_LUI    = 7'b011_0111,
    OP_BRANCH = 7'b110_0011,
    OP_JALR   = 7'b110_0111,
    OP_JAL    = 7'b110_1111,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  // sign-extended J-type immediate
  typedef logic [31:0] jimm_t;

  // reassemble imm[20|10:1|11|19:12] into a byte offset
  function automatic jimm_t j_imm(input logic [31:0] inst);
    return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

endpackage

/* tests/tb_clk_gen.sv */
// testbench clock and reset, 100 ns period with reset held low for the first 10 rising edges
`timescale 1ns/10ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_arst_n
);

  localparam int RESET_CYCLES = 10;

  initial begin
    o_clk    = 1'b0;
    o_arst_n = 1'b0;
    forever #50 o_clk = ~o_clk;  // 100 ns period
  end

  // release just after an edge, like the other inputs
  initial begin
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_arst_n = 1'b1;
  end

endmodule

/* tests/tb_fetch_top.sv */
// the program sits in a 4 KB window at the reset pc and every 7th word is a JAL
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module tb_fetch_top;
  import fetch_pkg::*;
  import isa_pkg::*;

  localparam int          N_STEADY       = 60;   // transfers with i_es_allowin held high
  localparam int          N_TOTAL        = 400;
  localparam int          N_REF          = N_TOTAL + 8;  // reads run a little ahead
  localparam int          TIMEOUT_CYCLES = 4 * N_TOTAL + 50;
  localparam logic [31:0] LFSR_SEED      = 32'h5581_7853;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;
  localparam logic [31:0] WINDOW_BYTES   = 32'd4096;

  logic       clk;
  logic       arst_n;
  logic       es_allowin;
  logic       sram_ren;
  sram_addr_t sram_addr;
  sram_data_t sram_rdata;
  sram_data_t sram_next;
  logic       id_valid;
  inst_t      id_inst;
  pc_t        id_pc;

  logic [31:0] rng_state = LFSR_SEED;
  pc_t         ref_pc [N_REF];
  inst_t       ref_inst [N_REF];
  int          xfer_count  = 0;
  int          fetch_idx   = 0;
  int          check_count = 0;
  int          error_count = 0;
  int          upper_seen  = 0;
  int          cycles      = 0;
  logic        wrong_path_ok = 1'b0;  // one sequential read may follow a JAL read
  logic        stall_q       = 1'b0;
  inst_t       held_inst;
  pc_t         held_pc;

  tb_clk_gen u_clk_gen (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  fetch_top i_dut (
    .i_clk             (clk),
    .i_arst_n          (arst_n),
    .i_es_allowin      (es_allowin),
    .o_inst_sram_ren   (sram_ren),
    .o_inst_sram_addr  (sram_addr),
    .i_inst_sram_rdata (sram_rdata),
    .o_id_valid        (id_valid),
    .o_id_inst         (id_inst),
    .o_id_pc           (id_pc)
  );

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // stimulus bits with one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] w;
    int          b;
    w = '0;
    for (b = 0; b < n; b++) begin
      w         = {w[30:0], rng_state[0]};
      rng_state = galois_step(rng_state);
    end
    return w;
  endfunction

  // 32 bits per address with the whole address folded into the start state
  function automatic logic [31:0] addr_bits(input pc_t addr);
    logic [31:0] s;
    logic [31:0] w;
    int          b;
    s = LFSR_SEED ^ addr;
    w = '0;
    for (b = 0; b < 32; b++) begin
      w = {w[30:0], s[0]};
      s = galois_step(s);
    end
    return w;
  endfunction

  function automatic logic in_window(input pc_t pc);
    pc_t ofs;
    ofs = pc - pc_t'(`FETCH_PC_RESETVAL);
    return ofs < WINDOW_BYTES;
  endfunction

  function automatic logic [9:0] word_index(input pc_t pc);
    pc_t ofs;
    ofs = pc - pc_t'(`FETCH_PC_RESETVAL);
    return ofs[11:2];
  endfunction

  // last word of the window is a JAL too, so the walk never runs off the end
  function automatic logic word_is_jal(input pc_t pc);
    logic [9:0] idx;
    idx = word_index(pc);
    return in_window(pc) && ((idx % 7 == 6) || (idx == 10'd1023));
  endfunction

  // target avoids the doubleword of pc+4, so wrong-path reads stay distinct
  function automatic pc_t jal_target(input pc_t pc);
    logic [31:0] rnd;
    logic [9:0]  idx;
    logic [9:0]  tidx;
    rnd  = addr_bits(pc);
    idx  = word_index(pc);
    tidx = rnd[9:0];
    if (tidx == idx || tidx == idx + 10'd1 || tidx == idx + 10'd2) begin
      tidx = tidx + 10'd3;
    end
    return pc_t'(`FETCH_PC_RESETVAL) + {tidx, 2'b00};
  endfunction

  function automatic inst_t jal_word(input pc_t pc, input pc_t target, input logic [4:0] rd);
    logic [31:0] off;
    off = target - pc;
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  function automatic inst_t mem_word(input pc_t pc);
    logic [31:0] rnd;
    rnd = addr_bits(pc);
    if (word_is_jal(pc)) begin
      return jal_word(pc, jal_target(pc), rnd[15:11]);
    end
    return {rnd[31:7], OP_IMM};  // never a JAL
  endfunction

  function automatic sram_data_t dword_at(input sram_addr_t addr);
    return {mem_word(addr + 32'd4), mem_word(addr)};
  endfunction

  function automatic sram_addr_t dword_of(input pc_t pc);
    return {pc[31:3], 3'b000};
  endfunction

  // next pc of the program in the reference walk
  function automatic pc_t ref_next_pc(input pc_t pc);
    return word_is_jal(pc) ? jal_target(pc) : pc + 32'd4;
  endfunction

  task automatic build_reference();
    int k;
    ref_pc[0] = pc_t'(`FETCH_PC_RESETVAL);
    for (k = 0; k < N_REF; k++) begin
      ref_inst[k] = mem_word(ref_pc[k]);
      if (k + 1 < N_REF) begin
        ref_pc[k+1] = ref_next_pc(ref_pc[k]);
      end
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("[ERROR] %t %s expected %h actual %h", $realtime, name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("%t %s", $realtime, msg);
  endtask

  task automatic finish_run();
    $display("transfers %0d, checks %0d, errors %0d", xfer_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // every read must be the next pc of the walk, or the one wrong-path word after a JAL
  task automatic check_read(input sram_addr_t addr);
    if (fetch_idx < N_REF && addr == dword_of(ref_pc[fetch_idx])) begin
      wrong_path_ok = word_is_jal(ref_pc[fetch_idx]);
      fetch_idx++;
    end else if (wrong_path_ok && fetch_idx > 0 &&
                 addr == dword_of(ref_pc[fetch_idx-1] + 32'd4)) begin
      wrong_path_ok = 1'b0;
    end else begin
      report_failure($sformatf("SRAM read of %h is not the next fetch in program order", addr));
    end
  endtask

  task automatic check_output(input inst_t inst, input pc_t pc);
    int k;
    k = xfer_count;
    check_value("o_id_pc", ref_pc[k], pc);
    check_value("o_id_inst", ref_inst[k], inst);
    if (k == 0) begin
      check_value("o_id_inst", dword_at(pc_t'(`FETCH_PC_RESETVAL)) & 64'hFFFF_FFFF, inst);
    end else if (word_is_jal(ref_pc[k-1])) begin
      check_value("o_id_pc", jal_target(ref_pc[k-1]), pc);
      if (pc == ref_pc[k-1] + 32'd4) begin
        report_failure("the word after an accepted JAL was delivered");
      end
    end else if (k < N_STEADY) begin
      check_value("o_id_pc", ref_pc[k-1] + 32'd4, pc);  // plain step of 4
    end
    if (k < N_STEADY && pc[2]) begin
      upper_seen++;
    end
    xfer_count++;
  endtask

  // SRAM answers one cycle after ren and holds otherwise
  initial sram_rdata = '0;
  always @(posedge clk) begin
    if (sram_ren) begin
      sram_next = dword_at(sram_addr);
      #1;
      sram_rdata = sram_next;
    end
  end

  initial begin
    es_allowin = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (xfer_count < N_STEADY) begin
        es_allowin = 1'b1;
      end else begin
        es_allowin = (take_bits(2) != 2'b00);  // high three times in four
      end
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!arst_n) begin
      check_value("o_id_valid", 1'b0, id_valid);
      check_value("o_inst_sram_ren", 1'b0, sram_ren);
    end else begin
      if (stall_q) begin
        check_value("o_id_valid", 1'b1, id_valid);
        check_value("o_id_inst", held_inst, id_inst);
        check_value("o_id_pc", held_pc, id_pc);
      end
      stall_q   = id_valid && !es_allowin;
      held_inst = id_inst;
      held_pc   = id_pc;
      if (sram_ren) begin
        check_read(sram_addr);
      end
      if (id_valid && es_allowin && xfer_count < N_TOTAL) begin
        check_output(id_inst, id_pc);
      end
    end
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    report_failure($sformatf("timeout after %0d cycles with %0d of %0d transfers done",
                             cycles, xfer_count, N_TOTAL));
    finish_run();
  end

  initial begin
    $timeformat(-9, 1, " ns", 10);
    build_reference();
    wait (xfer_count == N_TOTAL);
    if (upper_seen == 0) begin
      report_failure("no instruction from an upper half was delivered in the steady phase");
    end
    finish_run();
  end

endmodule
